// File: Bender.yml
package:
  name: riscv_exec

sources:
  - files:
      - verilog/riscv_pkg.sv
      - verilog/riscv_decode.sv
      - verilog/riscv_regfile.sv
      - verilog/riscv_issue.sv
      - verilog/riscv_alu.sv
      - verilog/riscv_writeback.sv
      - verilog/riscv_exec_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/riscv_exec_tb.sv

// File: sim/riscv_ref_model.svh
`ifndef RISCV_REF_MODEL_SVH
`define RISCV_REF_MODEL_SVH

// sequential model state, x0 is never written
logic [XLEN-1:0]      model_regs [REG_COUNT];
int unsigned          legal_count;

// expected outputs in issue order
bit                   exp_trap_q [$];
logic [REG_WIDTH-1:0] exp_addr_q [$];
logic [XLEN-1:0]      exp_data_q [$];
string                exp_name_q [$];

function automatic void clear_model();
  foreach (model_regs[i]) begin
    model_regs[i] = '0;
  end
  legal_count = 0;
endfunction

// RV64I OP and OP-IMM encodings only
function automatic bit is_legal_encoding(input logic [31:0] ins);
  logic [6:0] f7;
  logic [2:0] f3;
  f7 = ins[31:25];
  f3 = ins[14:12];
  if (ins[6:0] == 7'b0110011) begin
    return (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
  end else if (ins[6:0] == 7'b0010011) begin
    if (f3 == 3'd1) begin
      return ins[31:26] == 6'h00;
    end else if (f3 == 3'd5) begin
      return (ins[31:26] == 6'h00) || (ins[31:26] == 6'h10);
    end
    return 1'b1;
  end
  return 1'b0;
endfunction

function automatic void predict_result(input logic [31:0] ins, input string name);
  logic [XLEN-1:0]        a;
  logic [XLEN-1:0]        b;
  logic [XLEN-1:0]        r;
  logic signed [XLEN-1:0] sa;
  logic [5:0]             sh;
  logic [4:0]             rd;
  logic                   is_reg;
  if (!is_legal_encoding(ins)) begin
    exp_trap_q.push_back(1'b1);
    exp_addr_q.push_back('0);
    exp_data_q.push_back('0);
    exp_name_q.push_back(name);
    return;
  end
  rd     = ins[11:7];
  is_reg = (ins[6:0] == 7'b0110011);
  a      = model_regs[ins[19:15]];
  b      = is_reg ? model_regs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
  sa     = a;
  sh     = b[5:0];
  case (ins[14:12])
    3'd0: r = (is_reg && ins[30]) ? a - b : a + b;
    3'd1: r = a << sh;
    3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    3'd3: r = (a < b) ? 64'd1 : 64'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      if (ins[30]) begin
        r = sa >>> sh;
      end else begin
        r = a >> sh;
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  if (rd != 5'd0) begin
    model_regs[rd] = r;
  end
  legal_count++;
  exp_trap_q.push_back(1'b0);
  exp_addr_q.push_back(rd);
  exp_data_q.push_back(r);
  exp_name_q.push_back(name);
endfunction

`endif

// File: sim/riscv_exec_tb.sv
`timescale 1ns/100ps

module riscv_exec_tb;

  import riscv_pkg::*;

  `include "riscv_ref_model.svh"

  logic                   clk;
  logic                   arst_n;
  logic                   instr_valid;
  logic [INSTR_WIDTH-1:0] instr;
  logic                   wb_valid;
  logic [REG_WIDTH-1:0]   wb_addr;
  logic [XLEN-1:0]        wb_data;
  logic                   trap;
  logic [31:0]            retired_count;

  riscv_exec_top u_riscv_exec_top (
    .clk           (clk),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .wb_valid      (wb_valid),
    .wb_addr       (wb_addr),
    .wb_data       (wb_data),
    .trap          (trap),
    .retired_count (retired_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] pick_legal(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'($urandom_range(7, 0));
    alt = 1'($urandom_range(1, 0));
    imm = 12'($urandom);
    if ($urandom_range(1, 0) == 1) begin
      if ((f3 != F3_ADD) && (f3 != F3_SR)) begin
        alt = 1'b0;
      end
      return r_type(alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd);
    end
    // immediate shifts keep only shamt and the sra flag
    if (f3 == F3_SLL) begin
      imm[11:6] = 6'b0;
    end else if (f3 == F3_SR) begin
      imm[11:6] = alt ? 6'b010000 : 6'b000000;
    end
    return i_type(imm, rs1, f3, rd);
  endfunction

  function automatic logic [31:0] make_illegal();
    logic [31:0] ins;
    for (int t = 0; t < 64; t++) begin
      ins = $urandom;
      // about half hit the supported opcodes with bad funct bits
      if (ins[0]) begin
        ins[6:0] = ins[1] ? OPC_OP : OPC_OP_IMM;
      end
      if (!is_legal_encoding(ins)) begin
        return ins;
      end
    end
    return 32'hffff_ffff;
  endfunction

  task automatic send_instr(input logic [31:0] ins, input string name, input int gap);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= ins;
    predict_result(ins, name);
    repeat (gap) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
  endtask

  task automatic stop_driving();
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_trap_q.size() != 0) && (cycles < 200)) begin
      @(negedge clk);
      cycles++;
    end
    assert (exp_trap_q.size() == 0)
      else fail_run("timeout: results still outstanding after 200 cycles");
  endtask

  task automatic check_output();
    bit                   exp_trap;
    logic [REG_WIDTH-1:0] exp_addr;
    logic [XLEN-1:0]      exp_data;
    string                name;
    assert (exp_trap_q.size() != 0)
      else fail_run("output strobe seen with no instruction outstanding");
    exp_trap = exp_trap_q.pop_front();
    exp_addr = exp_addr_q.pop_front();
    exp_data = exp_data_q.pop_front();
    name     = exp_name_q.pop_front();
    assert (!(wb_valid && trap))
      else fail_run("wb_valid and trap are high in the same cycle");
    assert (trap == exp_trap)
      else fail_run($sformatf("ERR %s trap: expected %0d, actual %0d", name, exp_trap, trap));
    if (!exp_trap) begin
      assert (wb_addr == exp_addr)
        else fail_run($sformatf("ERR %s addr: expected %0d, actual %0d",
                                name, exp_addr, wb_addr));
      assert (wb_data == exp_data)
        else fail_run($sformatf("ERR %s data: expected %h, actual %h",
                                name, exp_data, wb_data));
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n && (wb_valid || trap)) begin
      check_output();
    end
  end

  initial begin
    int unsigned seed_ret;
    logic [31:0] ins;
    seed_ret    = $urandom(32'h5568);
    instr_valid = 1'b0;
    instr       = '0;
    arst_n      = 1'b0;
    clear_model();
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    // every register reads zero after reset
    for (int r = 0; r < REG_COUNT; r++) begin
      send_instr(r_type(F7_BASE, 5'd0, 5'(r), F3_ADD, 5'(r)), "reset", 0);
    end

    // spread random bits over all 64 bits of each register
    for (int k = 0; k < 3; k++) begin
      for (int r = 1; r < REG_COUNT; r++) begin
        send_instr(i_type(12'($urandom), 5'(r), F3_XOR, 5'(r)), "fill", $urandom_range(3, 0));
        send_instr(i_type(12'd21, 5'(r), F3_SLL, 5'(r)), "fill", $urandom_range(3, 0));
      end
    end

    // shift amounts 0 and 63, signed against unsigned compares
    send_instr(i_type(12'h03f, 5'd0, F3_ADD, 5'd7), "edges", 0);
    send_instr(i_type(12'hfff, 5'd0, F3_ADD, 5'd8), "edges", 0);
    send_instr(i_type(12'h000, 5'd3, F3_SLL, 5'd9), "edges", 1);
    send_instr(i_type(12'h03f, 5'd3, F3_SLL, 5'd9), "edges", 1);
    send_instr(i_type(12'h03f, 5'd3, F3_SR, 5'd9), "edges", 1);
    send_instr(i_type(12'h43f, 5'd3, F3_SR, 5'd9), "edges", 1);
    send_instr(i_type(12'h400, 5'd3, F3_SR, 5'd9), "edges", 1);
    send_instr(r_type(F7_BASE, 5'd7, 5'd3, F3_SLL, 5'd9), "edges", 1);
    send_instr(r_type(F7_ALT, 5'd7, 5'd3, F3_SR, 5'd9), "edges", 1);
    send_instr(r_type(F7_BASE, 5'd3, 5'd8, F3_SLT, 5'd9), "edges", 1);
    send_instr(r_type(F7_BASE, 5'd3, 5'd8, F3_SLTU, 5'd9), "edges", 1);
    send_instr(i_type(12'h000, 5'd8, F3_SLT, 5'd9), "edges", 1);
    send_instr(i_type(12'hfff, 5'd8, F3_SLTU, 5'd9), "edges", 1);

    // producer and consumer at distances 1 to 4
    for (int d = 1; d <= 4; d++) begin
      send_instr(i_type(12'($urandom), 5'd4, F3_XOR, 5'd5), "dep", 0);
      for (int k = 1; k < d; k++) begin
        send_instr(i_type(12'($urandom), 5'd6, F3_ADD, 5'(10 + k)), "dep", 0);
      end
      send_instr(r_type(F7_ALT, 5'd4, 5'd5, F3_ADD, 5'd6), "dep", 0);
      send_instr(r_type(F7_BASE, 5'd6, 5'd5, F3_XOR, 5'd6), "dep", 0);
    end

    // results to x0 are reported but never stored
    send_instr(i_type(12'h123, 5'd3, F3_ADD, 5'd0), "x0", 0);
    send_instr(r_type(F7_BASE, 5'd4, 5'd3, F3_XOR, 5'd0), "x0", 0);
    send_instr(r_type(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd13), "x0", 0);
    send_instr(i_type(12'h7ff, 5'd0, F3_ADD, 5'd14), "x0", 2);

    // random mix with illegal encodings
    for (int n = 0; n < 400; n++) begin
      if ($urandom_range(7, 0) == 0) begin
        ins = make_illegal();
      end else begin
        ins = pick_legal(5'($urandom), 5'($urandom), 5'($urandom));
      end
      send_instr(ins, is_legal_encoding(ins) ? "random" : "illegal", $urandom_range(3, 0));
    end

    stop_driving();
    wait_drain();
    @(posedge clk);
    @(negedge clk);
    assert (retired_count == legal_count)
      else fail_run($sformatf("ERR retired: expected %0d, actual %0d",
                              legal_count, retired_count));
    $display("Test OK");
    $finish;
  end

endmodule

// File: sources.f
+incdir+sim
verilog/riscv_pkg.sv
verilog/riscv_decode.sv
verilog/riscv_regfile.sv
verilog/riscv_issue.sv
verilog/riscv_alu.sv
verilog/riscv_writeback.sv
verilog/riscv_exec_top.sv
sim/riscv_exec_tb.sv

// File: verilog/riscv_alu.sv
`timescale 1ns/100ps

module riscv_alu (
  input  logic                            clk,
  input  logic                            arst_n,

  input  logic                            ex_valid,
  input  logic                            ex_illegal,
  input  riscv_pkg::alu_op_e              ex_op,
  input  logic [riscv_pkg::XLEN-1:0]      ex_a,
  input  logic [riscv_pkg::XLEN-1:0]      ex_b,
  input  logic [riscv_pkg::REG_WIDTH-1:0] ex_rd,

  // unregistered result, forwarded to issue
  output logic                            alu_fwd_valid,
  output logic [riscv_pkg::REG_WIDTH-1:0] alu_fwd_rd,
  output logic [riscv_pkg::XLEN-1:0]      alu_fwd_data,

  output logic                            res_valid,
  output logic                            res_illegal,
  output logic [riscv_pkg::REG_WIDTH-1:0] res_rd,
  output logic [riscv_pkg::XLEN-1:0]      res_data
);

  import riscv_pkg::*;

  logic [5:0]      shamt;
  logic [XLEN-1:0] result;

  // RV64 shift amount
  assign shamt = ex_b[5:0];

  always_comb begin
    case (ex_op)
      ALU_ADD:  result = ex_a + ex_b;
      ALU_SUB:  result = ex_a - ex_b;
      ALU_SLL:  result = ex_a << shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(ex_a) < $signed(ex_b))};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, (ex_a < ex_b)};
      ALU_XOR:  result = ex_a ^ ex_b;
      ALU_SRL:  result = ex_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(ex_a) >>> shamt);
      ALU_OR:   result = ex_a | ex_b;
      ALU_AND:  result = ex_a & ex_b;
      default:  result = '0;
    endcase
  end

  // x0 and traps never forward
  assign alu_fwd_valid = ex_valid & ~ex_illegal & (ex_rd != '0);
  assign alu_fwd_rd    = ex_rd;
  assign alu_fwd_data  = result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid   <= 1'b0;
      res_illegal <= 1'b0;
    end else begin
      res_valid   <= ex_valid;
      res_illegal <= ex_valid & ex_illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      res_rd   <= ex_rd;
      res_data <= result;
    end
  end

endmodule

// File: verilog/riscv_decode.sv
`timescale 1ns/100ps

module riscv_decode (
  input  logic                             clk,
  input  logic                             arst_n,

  input  logic                             instr_valid,
  input  logic [riscv_pkg::INSTR_WIDTH-1:0] instr,

  output logic                             dec_valid,
  output logic                             dec_illegal,
  output riscv_pkg::alu_op_e               dec_op,
  output logic [riscv_pkg::REG_WIDTH-1:0]  dec_rs1,
  output logic [riscv_pkg::REG_WIDTH-1:0]  dec_rs2,
  output logic [riscv_pkg::REG_WIDTH-1:0]  dec_rd,
  output logic [riscv_pkg::XLEN-1:0]       dec_imm,
  output logic                             dec_use_imm
);

  import riscv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  logic       is_op;
  logic       is_op_imm;
  logic       alt;
  alu_op_e    op_d;
  logic       illegal_d;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign funct6    = instr[31:26];
  assign is_op     = (opcode == OPC_OP);
  assign is_op_imm = (opcode == OPC_OP_IMM);

  // immediate shifts carry shamt[5] in bit 25
  assign alt = is_op ? (funct7 == F7_ALT) : (funct6 == F7_ALT[6:1]);

  always_comb begin
    case (funct3)
      F3_ADD:  op_d = (is_op && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op_d = ALU_SLL;
      F3_SLT:  op_d = ALU_SLT;
      F3_SLTU: op_d = ALU_SLTU;
      F3_XOR:  op_d = ALU_XOR;
      F3_SR:   op_d = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op_d = ALU_OR;
      default: op_d = ALU_AND;
    endcase
  end

  always_comb begin
    illegal_d = 1'b0;
    if (is_op) begin
      // only add/sub and srl/sra have an alternate form
      illegal_d = !((funct7 == F7_BASE) ||
                    ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR))));
    end else if (is_op_imm) begin
      if (funct3 == F3_SLL) begin
        illegal_d = (funct6 != F7_BASE[6:1]);
      end else if (funct3 == F3_SR) begin
        illegal_d = !((funct6 == F7_BASE[6:1]) || alt);
      end
    end else begin
      illegal_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid   <= 1'b0;
      dec_illegal <= 1'b0;
      dec_use_imm <= 1'b0;
    end else begin
      dec_valid   <= instr_valid;
      dec_illegal <= instr_valid & illegal_d;
      dec_use_imm <= instr_valid & is_op_imm;
    end
  end

  // fields held until the next strobe
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec_op  <= op_d;
      dec_rs1 <= instr[19:15];
      dec_rs2 <= instr[24:20];
      dec_rd  <= instr[11:7];
      dec_imm <= {{(XLEN-12){instr[31]}}, instr[31:20]};
    end
  end

  // bit 30 of an OP-IMM immediate never selects sub
  a_imm_never_sub: assert property (
    @(posedge clk) disable iff (!arst_n) dec_use_imm |-> (dec_op != ALU_SUB)
  );

endmodule

// File: verilog/riscv_exec_top.sv
`timescale 1ns/100ps

module riscv_exec_top (
  input  logic                              clk,
  input  logic                              arst_n,

  input  logic                              instr_valid,
  input  logic [riscv_pkg::INSTR_WIDTH-1:0] instr,

  output logic                              wb_valid,
  output logic [riscv_pkg::REG_WIDTH-1:0]   wb_addr,
  output logic [riscv_pkg::XLEN-1:0]        wb_data,
  output logic                              trap,
  output logic [31:0]                       retired_count
);

  import riscv_pkg::*;

  // decode to issue
  logic                 dec_valid;
  logic                 dec_illegal;
  alu_op_e              dec_op;
  logic [REG_WIDTH-1:0] dec_rs1;
  logic [REG_WIDTH-1:0] dec_rs2;
  logic [REG_WIDTH-1:0] dec_rd;
  logic [XLEN-1:0]      dec_imm;
  logic                 dec_use_imm;

  // register file ports
  logic [REG_WIDTH-1:0] rs1_addr;
  logic [REG_WIDTH-1:0] rs2_addr;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic                 rd_en;
  logic [REG_WIDTH-1:0] rd_addr;
  logic [XLEN-1:0]      rd_data;

  // issue to ALU
  logic                 ex_valid;
  logic                 ex_illegal;
  alu_op_e              ex_op;
  logic [XLEN-1:0]      ex_a;
  logic [XLEN-1:0]      ex_b;
  logic [REG_WIDTH-1:0] ex_rd;

  // ALU forward and result
  logic                 alu_fwd_valid;
  logic [REG_WIDTH-1:0] alu_fwd_rd;
  logic [XLEN-1:0]      alu_fwd_data;
  logic                 res_valid;
  logic                 res_illegal;
  logic [REG_WIDTH-1:0] res_rd;
  logic [XLEN-1:0]      res_data;

  riscv_decode u_riscv_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec_valid   (dec_valid),
    .dec_illegal (dec_illegal),
    .dec_op      (dec_op),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_rd      (dec_rd),
    .dec_imm     (dec_imm),
    .dec_use_imm (dec_use_imm)
  );

  riscv_regfile u_riscv_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .rs2_addr (rs2_addr),
    .rs2_data (rs2_data),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  riscv_issue u_riscv_issue (
    .clk           (clk),
    .arst_n        (arst_n),
    .dec_valid     (dec_valid),
    .dec_illegal   (dec_illegal),
    .dec_op        (dec_op),
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .dec_rd        (dec_rd),
    .dec_imm       (dec_imm),
    .dec_use_imm   (dec_use_imm),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .alu_fwd_valid (alu_fwd_valid),
    .alu_fwd_rd    (alu_fwd_rd),
    .alu_fwd_data  (alu_fwd_data),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .ex_valid      (ex_valid),
    .ex_illegal    (ex_illegal),
    .ex_op         (ex_op),
    .ex_a          (ex_a),
    .ex_b          (ex_b),
    .ex_rd         (ex_rd)
  );

  riscv_alu u_riscv_alu (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex_valid      (ex_valid),
    .ex_illegal    (ex_illegal),
    .ex_op         (ex_op),
    .ex_a          (ex_a),
    .ex_b          (ex_b),
    .ex_rd         (ex_rd),
    .alu_fwd_valid (alu_fwd_valid),
    .alu_fwd_rd    (alu_fwd_rd),
    .alu_fwd_data  (alu_fwd_data),
    .res_valid     (res_valid),
    .res_illegal   (res_illegal),
    .res_rd        (res_rd),
    .res_data      (res_data)
  );

  riscv_writeback u_riscv_writeback (
    .clk           (clk),
    .arst_n        (arst_n),
    .res_valid     (res_valid),
    .res_illegal   (res_illegal),
    .res_rd        (res_rd),
    .res_data      (res_data),
    .wb_valid      (wb_valid),
    .wb_addr       (wb_addr),
    .wb_data       (wb_data),
    .trap          (trap),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .retired_count (retired_count)
  );

endmodule

// File: verilog/riscv_issue.sv
`timescale 1ns/100ps

module riscv_issue (
  input  logic                            clk,
  input  logic                            arst_n,

  // from decode
  input  logic                            dec_valid,
  input  logic                            dec_illegal,
  input  riscv_pkg::alu_op_e              dec_op,
  input  logic [riscv_pkg::REG_WIDTH-1:0] dec_rs1,
  input  logic [riscv_pkg::REG_WIDTH-1:0] dec_rs2,
  input  logic [riscv_pkg::REG_WIDTH-1:0] dec_rd,
  input  logic [riscv_pkg::XLEN-1:0]      dec_imm,
  input  logic                            dec_use_imm,

  // register file read ports
  output logic [riscv_pkg::REG_WIDTH-1:0] rs1_addr,
  output logic [riscv_pkg::REG_WIDTH-1:0] rs2_addr,
  input  logic [riscv_pkg::XLEN-1:0]      rs1_data,
  input  logic [riscv_pkg::XLEN-1:0]      rs2_data,

  // forward from the instruction now in the ALU
  input  logic                            alu_fwd_valid,
  input  logic [riscv_pkg::REG_WIDTH-1:0] alu_fwd_rd,
  input  logic [riscv_pkg::XLEN-1:0]      alu_fwd_data,

  // forward from the instruction now in writeback
  input  logic                            rd_en,
  input  logic [riscv_pkg::REG_WIDTH-1:0] rd_addr,
  input  logic [riscv_pkg::XLEN-1:0]      rd_data,

  // to the ALU
  output logic                            ex_valid,
  output logic                            ex_illegal,
  output riscv_pkg::alu_op_e              ex_op,
  output logic [riscv_pkg::XLEN-1:0]      ex_a,
  output logic [riscv_pkg::XLEN-1:0]      ex_b,
  output logic [riscv_pkg::REG_WIDTH-1:0] ex_rd
);

  import riscv_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;

  // youngest producer wins; neither forward source ever targets x0
  function automatic logic [XLEN-1:0] pick_operand(
    input logic [REG_WIDTH-1:0] addr,
    input logic [XLEN-1:0]      rf_data,
    input logic                 alu_hit_en,
    input logic [REG_WIDTH-1:0] alu_rd,
    input logic [XLEN-1:0]      alu_data,
    input logic                 wb_hit_en,
    input logic [REG_WIDTH-1:0] wb_rd,
    input logic [XLEN-1:0]      wb_data
  );
    if (alu_hit_en && (alu_rd == addr)) begin
      return alu_data;
    end else if (wb_hit_en && (wb_rd == addr)) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  assign rs1_addr = dec_rs1;
  assign rs2_addr = dec_rs2;

  always_comb begin
    op_a = pick_operand(dec_rs1, rs1_data, alu_fwd_valid, alu_fwd_rd, alu_fwd_data,
                        rd_en, rd_addr, rd_data);
    op_b = pick_operand(dec_rs2, rs2_data, alu_fwd_valid, alu_fwd_rd, alu_fwd_data,
                        rd_en, rd_addr, rd_data);
    // OP-IMM takes the immediate as operand b
    if (dec_use_imm) begin
      op_b = dec_imm;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid   <= 1'b0;
      ex_illegal <= 1'b0;
    end else begin
      ex_valid   <= dec_valid;
      ex_illegal <= dec_valid & dec_illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_op <= dec_op;
      ex_a  <= op_a;
      ex_b  <= op_b;
      ex_rd <= dec_rd;
    end
  end

endmodule

// File: verilog/riscv_pkg.sv
package riscv_pkg;

  // datapath and register file geometry
  localparam int XLEN        = 64;
  localparam int REG_WIDTH   = 5;
  localparam int REG_COUNT   = 32;
  localparam int INSTR_WIDTH = 32;

  // major opcodes of the two supported classes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // upper funct codes
  // alt selects sub on OP and sra on both classes;
  // RV64 immediate shifts compare only bits [6:1]
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

endpackage

// File: verilog/riscv_regfile.sv
`timescale 1ns/100ps

module riscv_regfile (
  input  logic                            clk,
  input  logic                            arst_n,

  input  logic [riscv_pkg::REG_WIDTH-1:0] rs1_addr,
  output logic [riscv_pkg::XLEN-1:0]      rs1_data,

  input  logic [riscv_pkg::REG_WIDTH-1:0] rs2_addr,
  output logic [riscv_pkg::XLEN-1:0]      rs2_data,

  input  logic                            rd_en,
  input  logic [riscv_pkg::REG_WIDTH-1:0] rd_addr,
  input  logic [riscv_pkg::XLEN-1:0]      rd_data
);

  import riscv_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] gpr [1:REG_COUNT-1];

  // asynchronous read ports
  assign rs1_data = (rs1_addr == '0) ? '0 : gpr[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : gpr[rs2_addr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < REG_COUNT; i++) begin
        gpr[i] <= '0;
      end
    end else if (rd_en && (rd_addr != '0)) begin
      gpr[rd_addr] <= rd_data;
    end
  end

  // writeback filters x0 before it gets here
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!arst_n) rd_en |-> (rd_addr != '0)
  );

endmodule

// File: verilog/riscv_writeback.sv
`timescale 1ns/100ps

module riscv_writeback (
  input  logic                            clk,
  input  logic                            arst_n,

  input  logic                            res_valid,
  input  logic                            res_illegal,
  input  logic [riscv_pkg::REG_WIDTH-1:0] res_rd,
  input  logic [riscv_pkg::XLEN-1:0]      res_data,

  output logic                            wb_valid,
  output logic [riscv_pkg::REG_WIDTH-1:0] wb_addr,
  output logic [riscv_pkg::XLEN-1:0]      wb_data,
  output logic                            trap,

  output logic                            rd_en,
  output logic [riscv_pkg::REG_WIDTH-1:0] rd_addr,
  output logic [riscv_pkg::XLEN-1:0]      rd_data,

  output logic [31:0]                     retired_count
);

  // results to x0 are still reported
  assign wb_valid = res_valid & ~res_illegal;
  assign wb_addr  = res_rd;
  assign wb_data  = res_data;
  assign trap     = res_valid & res_illegal;

  // register write lands on the next edge
  assign rd_en   = wb_valid & (res_rd != '0);
  assign rd_addr = res_rd;
  assign rd_data = res_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retired_count <= '0;
    end else if (wb_valid) begin
      retired_count <= retired_count + 32'd1;
    end
  end

  // a trap flag only arrives with its strobe
  a_trap_needs_valid: assert property (
    @(posedge clk) disable iff (!arst_n) res_illegal |-> res_valid
  );

endmodule
